// File: hdl/rx_pkg.sv
`default_nettype none
// ========================================
// rx receive path shared definitions
// block geometry, word widths and state types
// ========================================

package rx_pkg;

    // coded block geometry
    localparam int RS_N = 16;
    localparam int RS_K = 12;
    localparam int SYM_W = 8;

    // ATI word side
    localparam int ATI_W = 32;
    localparam int ATI_BYTES = 4;
    localparam int BE_W = 2;
    localparam int FIFO_DEPTH = 8;

    // status counters
    localparam int CNT_W = 8;

    // holds 0 .. RS_N
    typedef logic [$clog2(RS_N + 1)-1:0] sym_idx_t;
    typedef logic [SYM_W-1:0] sym_t;
    typedef logic [ATI_W-1:0] ati_word_t;
    // valid bytes in the word minus one
    typedef logic [BE_W-1:0] ati_be_t;

    typedef enum logic [1:0] {
        BLK_IDLE,
        BLK_DATA,
        BLK_CHECK
    } blk_state_e;

    typedef enum logic {
        PACK_IDLE,
        PACK_FILL
    } pack_state_e;

endpackage

`default_nettype wire

// File: hdl/rx_block_framer.sv
`timescale 1ns/1ps
`default_nettype none
// ========================================
// rx block framer
// tags data and check symbols, forwards data only
// and keeps block and length-error counts
// ========================================

module rx_block_framer (
    input  logic                     parallel_clk_out,
    input  logic                     i_serial_rx_rst_n,
    input  logic                     i_rx_en,
    input  logic                     i_rx_sop,
    input  logic                     i_rx_eop,
    input  rx_pkg::sym_t             i_rx_data,
    output logic                     o_byte_val,
    output logic                     o_byte_sof,
    output logic                     o_byte_eof,
    output rx_pkg::sym_t             o_byte_data,
    output logic [rx_pkg::CNT_W-1:0] o_sync_cnt,
    output logic [rx_pkg::CNT_W-1:0] o_len_err_cnt
);
    import rx_pkg::*;

    blk_state_e state;
    // index of the next expected symbol
    sym_idx_t   sym_idx;
    sym_idx_t   cur_idx;
    logic       cur_open;
    logic       cur_data;
    logic       cur_last;

    // ========================================
    // current symbol classification
    // ========================================
    always_comb begin
        // sop opens a fresh block, also over one still open
        cur_open = i_rx_en && (i_rx_sop || state != BLK_IDLE);
        cur_idx  = i_rx_sop ? sym_idx_t'(0) : sym_idx;
        // index below RS_K is data
        cur_data = cur_open && (i_rx_sop || state == BLK_DATA);
        // block closes on eop or at the last check symbol
        cur_last = i_rx_eop || (cur_idx == sym_idx_t'(RS_N - 1));
    end

    always_ff @(posedge parallel_clk_out or negedge i_serial_rx_rst_n) begin
        if (!i_serial_rx_rst_n) begin
            state   <= BLK_IDLE;
            sym_idx <= '0;
        end else if (cur_open) begin
            if (cur_last) begin
                state   <= BLK_IDLE;
                sym_idx <= '0;
            end else begin
                sym_idx <= cur_idx + 1'b1;
                // next index reaches RS_K -> check region
                state   <= (cur_idx >= sym_idx_t'(RS_K - 1)) ? BLK_CHECK : BLK_DATA;
            end
        end
    end

    // ========================================
    // data byte output, one cycle late
    // ========================================
    always_ff @(posedge parallel_clk_out or negedge i_serial_rx_rst_n) begin
        if (!i_serial_rx_rst_n) begin
            o_byte_val <= 1'b0;
            o_byte_sof <= 1'b0;
            o_byte_eof <= 1'b0;
        end else begin
            o_byte_val <= cur_data;
            o_byte_sof <= cur_data && i_rx_sop;
            // last data symbol, or a short block ending early
            o_byte_eof <= cur_data && (i_rx_eop || cur_idx == sym_idx_t'(RS_K - 1));
        end
    end

    always_ff @(posedge parallel_clk_out) begin
        if (cur_data) begin
            o_byte_data <= i_rx_data;
        end
    end

    // block statistics, counters wrap
    always_ff @(posedge parallel_clk_out or negedge i_serial_rx_rst_n) begin
        if (!i_serial_rx_rst_n) begin
            o_sync_cnt    <= '0;
            o_len_err_cnt <= '0;
        end else if (cur_open && i_rx_eop) begin
            o_sync_cnt <= o_sync_cnt + 1'b1;
            if (cur_idx != sym_idx_t'(RS_N - 1)) begin
                o_len_err_cnt <= o_len_err_cnt + 1'b1;
            end
        end
    end

    // flags come only with a symbol
    a_flags_need_en: assert property (@(posedge parallel_clk_out)
        disable iff (!i_serial_rx_rst_n) (i_rx_sop || i_rx_eop) |-> i_rx_en);

    a_idx_in_block: assert property (@(posedge parallel_clk_out)
        disable iff (!i_serial_rx_rst_n) sym_idx <= sym_idx_t'(RS_N - 1));

endmodule

`default_nettype wire

// File: hdl/rx_word_packer.sv
`timescale 1ns/1ps
`default_nettype none
// ========================================
// rx word packer
// gathers data bytes into 32-bit ATI words, lane 0 first
// ========================================

module rx_word_packer (
    input  logic              parallel_clk_out,
    input  logic              i_serial_rx_rst_n,
    input  logic              i_byte_val,
    input  logic              i_byte_sof,
    input  logic              i_byte_eof,
    input  rx_pkg::sym_t      i_byte_data,
    output logic              o_word_val,
    output logic              o_word_sof,
    output logic              o_word_eof,
    output rx_pkg::ati_be_t   o_word_be,
    output rx_pkg::ati_word_t o_word_data
);
    import rx_pkg::*;

    pack_state_e state;
    // next free lane
    ati_be_t     lane_q;
    ati_word_t   acc_q;
    // partial word holds the sof byte
    logic        sof_q;
    logic        start;
    ati_be_t     lane;
    ati_word_t   acc_next;
    logic        sof_next;
    logic        last;

    // ========================================
    // lane placement
    // ========================================
    always_comb begin
        // a new frame drops any leftover partial word
        start    = (state == PACK_IDLE) || i_byte_sof;
        lane     = start ? ati_be_t'(0) : lane_q;
        // fresh word starts from zero so unused lanes stay clear
        acc_next = start ? ati_word_t'(0) : acc_q;
        acc_next[lane*SYM_W +: SYM_W] = i_byte_data;
        sof_next = start ? i_byte_sof : sof_q;
        last     = (lane == ati_be_t'(ATI_BYTES - 1)) || i_byte_eof;
    end

    always_ff @(posedge parallel_clk_out or negedge i_serial_rx_rst_n) begin
        if (!i_serial_rx_rst_n) begin
            state      <= PACK_IDLE;
            lane_q     <= '0;
            sof_q      <= 1'b0;
            o_word_val <= 1'b0;
        end else begin
            o_word_val <= i_byte_val && last;
            if (i_byte_val) begin
                if (last) begin
                    state  <= PACK_IDLE;
                    lane_q <= '0;
                    sof_q  <= 1'b0;
                end else begin
                    state  <= PACK_FILL;
                    lane_q <= lane + 1'b1;
                    sof_q  <= sof_next;
                end
            end
        end
    end

    // word payload and flags
    always_ff @(posedge parallel_clk_out) begin
        if (i_byte_val) begin
            acc_q <= acc_next;
            if (last) begin
                o_word_data <= acc_next;
                o_word_be   <= lane;
                o_word_sof  <= sof_next;
                o_word_eof  <= i_byte_eof;
            end
        end
    end

    // back to back only when a one-byte end word follows
    a_word_spacing: assert property (@(posedge parallel_clk_out)
        disable iff (!i_serial_rx_rst_n)
        o_word_val |=> !o_word_val || (o_word_eof && o_word_be == '0));

endmodule

`default_nettype wire

// File: hdl/rx_ati_fifo.sv
`timescale 1ns/1ps
`default_nettype none
// ========================================
// rx ATI word FIFO
// show-ahead buffer with ATI val/rdy output
// ========================================

module rx_ati_fifo (
    input  logic              parallel_clk_out,
    input  logic              i_serial_rx_rst_n,
    input  logic              i_word_val,
    input  logic              i_word_sof,
    input  logic              i_word_eof,
    input  rx_pkg::ati_be_t   i_word_be,
    input  rx_pkg::ati_word_t i_word_data,
    output logic              o_ati_val,
    output logic              o_ati_sof,
    output logic              o_ati_eof,
    output rx_pkg::ati_be_t   o_ati_be,
    output rx_pkg::ati_word_t o_ati_data,
    input  logic              i_ati_rdy,
    output logic              o_fifo_overflow
);
    import rx_pkg::*;

    ati_word_t mem_data [FIFO_DEPTH];
    ati_be_t   mem_be   [FIFO_DEPTH];
    logic      mem_sof  [FIFO_DEPTH];
    logic      mem_eof  [FIFO_DEPTH];

    logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(FIFO_DEPTH+1)-1:0] count;
    logic                            full;
    logic                            wr_en;
    logic                            rd_en;

    assign full  = (count == FIFO_DEPTH);
    // word into a full buffer is lost
    assign wr_en = i_word_val && !full;
    assign rd_en = o_ati_val && i_ati_rdy;

    // ========================================
    // storage
    // ========================================
    always_ff @(posedge parallel_clk_out) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= i_word_data;
            mem_be[wr_ptr]   <= i_word_be;
            mem_sof[wr_ptr]  <= i_word_sof;
            mem_eof[wr_ptr]  <= i_word_eof;
        end
    end

    // pointers wrap, depth is a power of two
    always_ff @(posedge parallel_clk_out or negedge i_serial_rx_rst_n) begin
        if (!i_serial_rx_rst_n) begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            count           <= '0;
            o_fifo_overflow <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // sticky until reset
            if (i_word_val && full) begin
                o_fifo_overflow <= 1'b1;
            end
        end
    end

    // head entry drives ATI directly
    assign o_ati_val  = (count != '0);
    assign o_ati_data = mem_data[rd_ptr];
    assign o_ati_be   = mem_be[rd_ptr];
    assign o_ati_sof  = mem_sof[rd_ptr];
    assign o_ati_eof  = mem_eof[rd_ptr];

    a_hold_on_stall: assert property (@(posedge parallel_clk_out)
        disable iff (!i_serial_rx_rst_n)
        o_ati_val && !i_ati_rdy |=> o_ati_val && $stable(o_ati_data)
            && $stable(o_ati_be) && $stable(o_ati_sof) && $stable(o_ati_eof));

endmodule

`default_nettype wire

// File: hdl/rx_top.sv
`timescale 1ns/1ps
`default_nettype none
// ========================================
// rx receive path top
// byte stream -> block framer -> packer -> ATI FIFO
// ========================================

module rx_top (
    input  logic                     parallel_clk_out,
    input  logic                     i_serial_rx_rst_n,
    input  logic                     i_rx_en,
    input  logic                     i_rx_sop,
    input  logic                     i_rx_eop,
    input  rx_pkg::sym_t             i_rx_data,
    output logic                     o_ati_val,
    output logic                     o_ati_sof,
    output logic                     o_ati_eof,
    output rx_pkg::ati_be_t          o_ati_be,
    output rx_pkg::ati_word_t        o_ati_data,
    input  logic                     i_ati_rdy,
    output logic                     o_fifo_overflow,
    output logic [rx_pkg::CNT_W-1:0] o_sync_cnt,
    output logic [rx_pkg::CNT_W-1:0] o_len_err_cnt
);
    import rx_pkg::*;

    // framer -> packer
    logic      byte_val;
    logic      byte_sof;
    logic      byte_eof;
    sym_t      byte_data;
    // packer -> FIFO
    logic      word_val;
    logic      word_sof;
    logic      word_eof;
    ati_be_t   word_be;
    ati_word_t word_data;

    // ========================================
    // block framing
    // ========================================
    rx_block_framer u_framer (
        .parallel_clk_out  (parallel_clk_out),
        .i_serial_rx_rst_n (i_serial_rx_rst_n),
        .i_rx_en           (i_rx_en),
        .i_rx_sop          (i_rx_sop),
        .i_rx_eop          (i_rx_eop),
        .i_rx_data         (i_rx_data),
        .o_byte_val        (byte_val),
        .o_byte_sof        (byte_sof),
        .o_byte_eof        (byte_eof),
        .o_byte_data       (byte_data),
        .o_sync_cnt        (o_sync_cnt),
        .o_len_err_cnt     (o_len_err_cnt)
    );

    // ========================================
    // word packing and ATI output
    // ========================================
    rx_word_packer u_packer (
        .parallel_clk_out  (parallel_clk_out),
        .i_serial_rx_rst_n (i_serial_rx_rst_n),
        .i_byte_val        (byte_val),
        .i_byte_sof        (byte_sof),
        .i_byte_eof        (byte_eof),
        .i_byte_data       (byte_data),
        .o_word_val        (word_val),
        .o_word_sof        (word_sof),
        .o_word_eof        (word_eof),
        .o_word_be         (word_be),
        .o_word_data       (word_data)
    );

    rx_ati_fifo u_fifo (
        .parallel_clk_out  (parallel_clk_out),
        .i_serial_rx_rst_n (i_serial_rx_rst_n),
        .i_word_val        (word_val),
        .i_word_sof        (word_sof),
        .i_word_eof        (word_eof),
        .i_word_be         (word_be),
        .i_word_data       (word_data),
        .o_ati_val         (o_ati_val),
        .o_ati_sof         (o_ati_sof),
        .o_ati_eof         (o_ati_eof),
        .o_ati_be          (o_ati_be),
        .o_ati_data        (o_ati_data),
        .i_ati_rdy         (i_ati_rdy),
        .o_fifo_overflow   (o_fifo_overflow)
    );

endmodule

`default_nettype wire

// File: tests/tb_rx_top.sv
`timescale 1ns/1ps
`default_nettype none
// ========================================
// rx_top testbench
// replays byte vectors, checks ATI words and counters
// ========================================

module tb_rx_top;
    import rx_pkg::*;

    localparam int MAX_REC     = 128;
    localparam int DRAIN_LIMIT = 200;

    logic                parallel_clk_out;
    logic                i_serial_rx_rst_n;
    logic                i_rx_en;
    logic                i_rx_sop;
    logic                i_rx_eop;
    sym_t                i_rx_data;
    logic                o_ati_val;
    logic                o_ati_sof;
    logic                o_ati_eof;
    ati_be_t             o_ati_be;
    ati_word_t           o_ati_data;
    logic                i_ati_rdy;
    logic                o_fifo_overflow;
    logic [CNT_W-1:0]    o_sync_cnt;
    logic [CNT_W-1:0]    o_len_err_cnt;

    // raw records, kind in the top hex digit
    logic [47:0]         vec_mem [MAX_REC];
    logic [47:0]         in_q [$];
    logic [47:0]         exp_q [$];
    logic [CNT_W-1:0]    exp_sync;
    logic [CNT_W-1:0]    exp_len_err;
    logic                have_counts;
    logic [31:0]         rng_state;
    int                  words_seen;

    rx_top i_dut (
        .parallel_clk_out  (parallel_clk_out),
        .i_serial_rx_rst_n (i_serial_rx_rst_n),
        .i_rx_en           (i_rx_en),
        .i_rx_sop          (i_rx_sop),
        .i_rx_eop          (i_rx_eop),
        .i_rx_data         (i_rx_data),
        .o_ati_val         (o_ati_val),
        .o_ati_sof         (o_ati_sof),
        .o_ati_eof         (o_ati_eof),
        .o_ati_be          (o_ati_be),
        .o_ati_data        (o_ati_data),
        .i_ati_rdy         (i_ati_rdy),
        .o_fifo_overflow   (o_fifo_overflow),
        .o_sync_cnt        (o_sync_cnt),
        .o_len_err_cnt     (o_len_err_cnt)
    );

    // 20 ns period
    always #10 parallel_clk_out = ~parallel_clk_out;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input logic got_sof, input logic got_eof, input ati_be_t got_be,
                              input ati_word_t got_data, input logic exp_sof,
                              input logic exp_eof, input ati_be_t exp_be,
                              input ati_word_t exp_data);
        if (got_sof !== exp_sof || got_eof !== exp_eof || got_be !== exp_be
            || got_data !== exp_data) begin
            stop_with_failure($sformatf(
                "Error: time %0t: word %0d got sof %b eof %b be %0d data %h, exp %b %b %0d %h",
                $time, words_seen, got_sof, got_eof, got_be, got_data,
                exp_sof, exp_eof, exp_be, exp_data));
        end
    endtask

    task automatic check_count(input string what, input logic [CNT_W-1:0] got,
                               input logic [CNT_W-1:0] want);
        if (got !== want) begin
            stop_with_failure($sformatf("Error: time %0t: %s is %0d, expected %0d",
                                        $time, what, got, want));
        end
    endtask

    // one clock: drive after the edge, look at ATI mid-cycle
    task automatic run_cycle(input logic en, input logic sop, input logic eop,
                             input sym_t data);
        logic [47:0] exp_rec;
        @(posedge parallel_clk_out);
        #2;
        i_rx_en   = en;
        i_rx_sop  = sop;
        i_rx_eop  = eop;
        i_rx_data = data;
        // ready in three cycles of four
        rng_state = xorshift32(rng_state);
        i_ati_rdy = (rng_state[1:0] != 2'b00);
        @(negedge parallel_clk_out);
        if (o_fifo_overflow) begin
            stop_with_failure("FIFO overflow flag was set, a word was dropped");
        end
        if (o_ati_val && i_ati_rdy) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("the DUT delivered a word that was not expected");
            end else begin
                exp_rec = exp_q.pop_front();
                check_word(o_ati_sof, o_ati_eof, o_ati_be, o_ati_data,
                           exp_rec[40], exp_rec[36], exp_rec[33:32], exp_rec[31:0]);
                words_seen++;
            end
        end
    endtask

    initial begin
        int          n;
        int          timeout;
        logic [47:0] rec;
        parallel_clk_out  = 1'b0;
        i_serial_rx_rst_n = 1'b0;
        i_rx_en           = 1'b0;
        i_rx_sop          = 1'b0;
        i_rx_eop          = 1'b0;
        i_rx_data         = '0;
        i_ati_rdy         = 1'b0;
        rng_state         = 32'hf13c8863;
        words_seen        = 0;
        exp_sync          = '0;
        exp_len_err       = '0;
        have_counts       = 1'b0;

        // ========================================
        // load vectors
        // ========================================
        $readmemh("tests/rx_top_vectors.txt", vec_mem);
        for (n = 0; n < MAX_REC; n++) begin
            rec = vec_mem[n];
            case (rec[47:44])
                4'h1: in_q.push_back(rec);
                4'h2: exp_q.push_back(rec);
                4'h3: begin
                    exp_sync    = rec[15:8];
                    exp_len_err = rec[7:0];
                    have_counts = 1'b1;
                end
                default: ;
            endcase
        end
        if (in_q.size() == 0 || !have_counts) begin
            stop_with_failure("the vector file is missing or holds no stimulus");
        end

        // reset for 2 cycles
        repeat (2) @(posedge parallel_clk_out);
        #2;
        i_serial_rx_rst_n = 1'b1;

        // ========================================
        // stimulus, one record per cycle
        // ========================================
        while (in_q.size() != 0) begin
            rec = in_q.pop_front();
            run_cycle(rec[40], rec[36], rec[32], rec[7:0]);
        end

        // drain the FIFO
        timeout = 0;
        while (exp_q.size() != 0 && timeout < DRAIN_LIMIT) begin
            run_cycle(1'b0, 1'b0, 1'b0, '0);
            timeout++;
        end
        if (exp_q.size() != 0) begin
            stop_with_failure($sformatf("timeout while waiting for %0d more words",
                                        exp_q.size()));
        end

        // quiet cycles, any extra word shows up here
        repeat (8) run_cycle(1'b0, 1'b0, 1'b0, '0);

        check_count("o_sync_cnt", o_sync_cnt, exp_sync);
        check_count("o_len_err_cnt", o_len_err_cnt, exp_len_err);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/rx_top_vectors.txt
// record = kind_a_b_c_data (hex); kind 1 input: a=en b=sop c=eop, data[7:0] = byte
// kind 2 expected word: a=sof b=eof c=be, data = word; kind 3 counts: data = sync, len_err
1_1_1_0_00000010
1_1_0_0_00000011
1_1_0_0_00000012
1_1_0_0_00000013
1_1_0_0_00000014
1_1_0_0_00000015
1_1_0_0_00000016
1_1_0_0_00000017
1_1_0_0_00000018
1_1_0_0_00000019
1_1_0_0_0000001a
1_1_0_0_0000001b
1_1_0_0_0000001c
1_1_0_0_0000001d
1_1_0_0_0000001e
1_1_0_1_0000001f
2_1_0_3_13121110
2_0_0_3_17161514
2_0_1_3_1b1a1918
// idle, then symbols outside any block
1_0_0_0_00000000
1_1_0_0_000000ee
1_1_0_0_000000ef
// short block, eop at index 6, idle gap inside
1_1_1_0_00000020
1_1_0_0_00000021
1_1_0_0_00000022
1_0_0_0_00000000
1_1_0_0_00000023
1_1_0_0_00000024
1_1_0_0_00000025
1_1_0_1_00000026
2_1_0_3_23222120
2_0_1_2_00262524
// eop at index 14, in the check region
1_1_1_0_00000030
1_1_0_0_00000031
1_1_0_0_00000032
1_1_0_0_00000033
1_1_0_0_00000034
1_1_0_0_00000035
1_1_0_0_00000036
1_1_0_0_00000037
1_1_0_0_00000038
1_1_0_0_00000039
1_1_0_0_0000003a
1_1_0_0_0000003b
1_1_0_0_0000003c
1_1_0_0_0000003d
1_1_0_1_0000003e
2_1_0_3_33323130
2_0_0_3_37363534
2_0_1_3_3b3a3938
3_0_0_0_00000302

// File: project.f
hdl/rx_pkg.sv
hdl/rx_block_framer.sv
hdl/rx_word_packer.sv
hdl/rx_ati_fifo.sv
hdl/rx_top.sv
tests/tb_rx_top.sv

// File: Bender.yml
package:
  name: rx_receive_path

sources:
  - hdl/rx_pkg.sv
  - hdl/rx_block_framer.sv
  - hdl/rx_word_packer.sv
  - hdl/rx_ati_fifo.sv
  - hdl/rx_top.sv
  - target: test
    files:
      - tests/tb_rx_top.sv
